// ==== verilog/key_display_settings.svh ====
// Screen geometry assumes 800x600 active video with 8x8 character cells and a 64-entry font ROM
`ifndef KEY_DISPLAY_SETTINGS_SVH
`define KEY_DISPLAY_SETTINGS_SVH

// Key statistics
`define HISTORY_LEN 31 // Characters kept on the history line
`define NUM_LETTERS 6 // Letters A to F

// Visible area
`define H_ACTIVE 800
`define V_ACTIVE 600
`define BORDER_OFFSET 32 // Border inset from each edge

// Text placement in pixels
`define HISTORY_LINE 280
`define COUNT_LINE 320
`define MESSAGE_START_COL 360
`define CELL_SHIFT 3 // 8 pixel cells

// Font ROM codes
`define CHAR_SPACE 6'o40
`define CHAR_DIGIT_BASE 6'o60 // Digit zero
`define CHAR_LETTER_A 6'o01 // Letters follow in order

// PS/2 set 2 make codes
`define SCAN_A 8'h1C
`define SCAN_B 8'h32
`define SCAN_C 8'h21
`define SCAN_D 8'h23
`define SCAN_E 8'h24
`define SCAN_F 8'h2B

`endif

// ==== verilog/key_display_pkg.sv ====
// Counts are two packed BCD digits, so the raw byte orders the same way as the decimal value
package key_display_pkg;

	// Font ROM address
	typedef logic [5:0] char_code_t;

	// One decimal digit, 0 to 9
	typedef logic [3:0] bcd_digit_t;

	// Press count, read as digits for display and as a byte for comparison
	typedef union packed {
		bcd_digit_t [1:0] digits; // [1] tens, [0] ones
		logic [7:0] raw;
	} bcd_count_u;

	// Screen position in pixels
	typedef logic [9:0] pixel_coord_t;

endpackage

// ==== verilog/key_event_decoder.sv ====
// Counts one event per rising edge of code_ready; a level held high or a break code adds nothing
`include "key_display_settings.svh"

module key_event_decoder
	import key_display_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,
	input logic [7:0] scan_code,
	input logic code_ready,
	input logic make_code,
	output logic key_valid,
	output char_code_t key_char,
	output logic [`NUM_LETTERS-1:0] letter_hit
);

	localparam logic [7:0] SCAN_TABLE [`NUM_LETTERS] = '{
		`SCAN_A, `SCAN_B, `SCAN_C, `SCAN_D, `SCAN_E, `SCAN_F
	};

	logic ready_q;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= code_ready;
		end
	end

	assign key_valid = code_ready && !ready_q && make_code; // New press only

	always_comb begin
		key_char = `CHAR_SPACE; // Unmonitored keys show as blank
		letter_hit = '0;
		for (int i = 0; i < `NUM_LETTERS; i++) begin
			if (key_valid && scan_code == SCAN_TABLE[i]) begin
				letter_hit[i] = 1'b1;
				key_char = char_code_t'(`CHAR_LETTER_A + i);
			end
		end
	end

	// At most one counter steps per event, and none between events
	a_letter_hit_onehot: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		$onehot0(letter_hit) && (key_valid || letter_hit == '0)
	);

endmodule

// ==== verilog/key_history.sv ====
// Entry 0 is the newest character; entries fall off the far end after HISTORY_LEN events
`include "key_display_settings.svh"

module key_history
	import key_display_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,
	input logic key_valid,
	input char_code_t key_char,
	output char_code_t history [`HISTORY_LEN]
);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			for (int i = 0; i < `HISTORY_LEN; i++) begin
				history[i] <= `CHAR_SPACE; // Blank line after reset
			end
		end else if (key_valid) begin
			history[0] <= key_char;
			for (int i = 1; i < `HISTORY_LEN; i++) begin
				history[i] <= history[i-1]; // Older keys move right to left on screen
			end
		end
	end

endmodule

// ==== verilog/bcd_letter_counter.sv ====
// Two decimal digits only; the count wraps from 99 back to 00 with no overflow flag
module bcd_letter_counter
	import key_display_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,
	input logic inc,
	output bcd_count_u count
);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			count.raw <= '0;
		end else if (inc) begin
			if (count.digits[0] == 4'd9) begin
				count.digits[0] <= 4'd0; // Carry into tens
				if (count.digits[1] == 4'd9) begin
					count.digits[1] <= 4'd0; // 99 wraps to 00
				end else begin
					count.digits[1] <= count.digits[1] + 4'd1;
				end
			end else begin
				count.digits[0] <= count.digits[0] + 4'd1;
			end
		end
	end

	// Raw byte comparison downstream relies on valid BCD
	a_digits_in_range: assert property (
		@(posedge CLOCK_50_I) disable iff (!resetn)
		count.digits[1] <= 4'd9 && count.digits[0] <= 4'd9
	);

endmodule

// ==== verilog/max_letter_select.sv ====
// Ties go to the earliest letter, A first; with every count at 00 the outputs point at A
`include "key_display_settings.svh"

module max_letter_select
	import key_display_pkg::*;
(
	input bcd_count_u counts [`NUM_LETTERS],
	output logic any_pressed,
	output char_code_t max_char,
	output bcd_count_u max_count
);

	always_comb begin
		max_count = counts[0];
		max_char = `CHAR_LETTER_A;
		for (int i = 1; i < `NUM_LETTERS; i++) begin
			if (counts[i].raw > max_count.raw) begin // Strictly greater keeps the earlier letter
				max_count = counts[i];
				max_char = char_code_t'(`CHAR_LETTER_A + i);
			end
		end
	end

	// Largest count is zero only when nothing was pressed
	assign any_pressed = (max_count.raw != '0);

endmodule

// ==== verilog/screen_overlay.sv ====
// Purely combinational; the caller must delay pixel_x itself if its font ROM has read latency
`include "key_display_settings.svh"

module screen_overlay
	import key_display_pkg::*;
(
	input pixel_coord_t pixel_x,
	input pixel_coord_t pixel_y,
	input char_code_t history [`HISTORY_LEN],
	input logic any_pressed,
	input char_code_t max_char,
	input bcd_count_u max_count,
	output char_code_t char_code,
	output logic border_on
);

	localparam int CELL_W = $bits(pixel_coord_t) - `CELL_SHIFT;

	localparam logic [CELL_W-1:0] START_CELL = CELL_W'(`MESSAGE_START_COL >> `CELL_SHIFT);
	localparam logic [CELL_W-1:0] HISTORY_ROW = CELL_W'(`HISTORY_LINE >> `CELL_SHIFT);
	localparam logic [CELL_W-1:0] COUNT_ROW = CELL_W'(`COUNT_LINE >> `CELL_SHIFT);

	localparam int NO_KEYS_LEN = 25;
	localparam logic [8*NO_KEYS_LEN-1:0] NO_KEYS_MSG = "NO MONITORED KEYS PRESSED";
	localparam int LETTER_POS = 4;
	localparam int PREFIX_LEN = 14;
	localparam logic [8*PREFIX_LEN-1:0] PREFIX_MSG = "KEY   PRESSED ";
	localparam int SUFFIX_LEN = 6;
	localparam logic [8*SUFFIX_LEN-1:0] SUFFIX_MSG = " TIMES";

	localparam pixel_coord_t BORDER_NEAR = `BORDER_OFFSET;
	localparam pixel_coord_t BORDER_RIGHT = `H_ACTIVE - `BORDER_OFFSET;
	localparam pixel_coord_t BORDER_BOTTOM = `V_ACTIVE - `BORDER_OFFSET;

	logic [CELL_W-1:0] cell_row;
	logic [CELL_W-1:0] cell_col;
	logic [CELL_W-1:0] col_off;
	logic in_text;
	logic two_digits;
	int num_len;
	char_code_t tens_char;
	char_code_t ones_char;

	// Maps upper case text, digits and space onto the font ROM order
	function automatic char_code_t ascii_to_char(input logic [7:0] c);
		char_code_t code;
		if (c == " ") begin
			code = `CHAR_SPACE;
		end else if (c >= "0" && c <= "9") begin
			code = `CHAR_DIGIT_BASE + char_code_t'(c - "0");
		end else begin
			code = `CHAR_LETTER_A + char_code_t'(c - "A");
		end
		return code;
	endfunction

	assign cell_row = pixel_y[$bits(pixel_coord_t)-1:`CELL_SHIFT];
	assign cell_col = pixel_x[$bits(pixel_coord_t)-1:`CELL_SHIFT];
	assign col_off = cell_col - START_CELL;
	assign in_text = (cell_col >= START_CELL);

	assign two_digits = (max_count.digits[1] != '0); // Leading zero suppressed
	assign num_len = two_digits ? 2 : 1;
	assign tens_char = `CHAR_DIGIT_BASE + char_code_t'(max_count.digits[1]);
	assign ones_char = `CHAR_DIGIT_BASE + char_code_t'(max_count.digits[0]);

	always_comb begin
		char_code = `CHAR_SPACE;
		if (in_text && cell_row == HISTORY_ROW) begin
			if (col_off < `HISTORY_LEN) begin
				char_code = history[`HISTORY_LEN - 1 - int'(col_off)]; // Newest at the right end
			end
		end else if (in_text && cell_row == COUNT_ROW) begin
			if (!any_pressed) begin
				if (col_off < NO_KEYS_LEN) begin
					char_code = ascii_to_char(NO_KEYS_MSG[8*(NO_KEYS_LEN-1-int'(col_off)) +: 8]);
				end
			end else if (col_off == LETTER_POS) begin
				char_code = max_char;
			end else if (col_off < PREFIX_LEN) begin
				char_code = ascii_to_char(PREFIX_MSG[8*(PREFIX_LEN-1-int'(col_off)) +: 8]);
			end else if (col_off < PREFIX_LEN + num_len) begin
				if (two_digits && col_off == PREFIX_LEN) begin
					char_code = tens_char;
				end else begin
					char_code = ones_char;
				end
			end else if (col_off < PREFIX_LEN + num_len + SUFFIX_LEN) begin
				// Suffix slides one cell right for two digit counts
				char_code = ascii_to_char(
					SUFFIX_MSG[8*(SUFFIX_LEN-1-(int'(col_off)-PREFIX_LEN-num_len)) +: 8]);
			end
		end
	end

	always_comb begin
		border_on = 1'b0;
		if (pixel_x == BORDER_NEAR || pixel_x == BORDER_RIGHT) begin
			if (pixel_y >= BORDER_NEAR && pixel_y < BORDER_BOTTOM) begin
				border_on = 1'b1; // Left and right edges
			end
		end
		if (pixel_y == BORDER_NEAR || pixel_y == BORDER_BOTTOM) begin
			if (pixel_x >= BORDER_NEAR && pixel_x < BORDER_RIGHT) begin
				border_on = 1'b1; // Top and bottom edges
			end
		end
	end

endmodule

// ==== verilog/key_stats_display.sv ====
// Expects decoded scan codes and pixel coordinates from outside; char_code feeds an external font ROM
`include "key_display_settings.svh"

module key_stats_display
	import key_display_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,
	input logic [7:0] scan_code,
	input logic code_ready,
	input logic make_code,
	input pixel_coord_t pixel_x,
	input pixel_coord_t pixel_y,
	output char_code_t char_code,
	output logic border_on
);

	logic key_valid;
	char_code_t key_char;
	logic [`NUM_LETTERS-1:0] letter_hit;

	char_code_t history [`HISTORY_LEN];
	bcd_count_u counts [`NUM_LETTERS];

	logic any_pressed;
	char_code_t max_char;
	bcd_count_u max_count;

	key_event_decoder decoder_unit (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.scan_code(scan_code),
		.code_ready(code_ready),
		.make_code(make_code),
		.key_valid(key_valid),
		.key_char(key_char),
		.letter_hit(letter_hit)
	);

	key_history history_unit (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.key_valid(key_valid),
		.key_char(key_char),
		.history(history)
	);

	// One counter per monitored letter
	for (genvar i = 0; i < `NUM_LETTERS; i++) begin : g_letter
		bcd_letter_counter counter_unit (
			.CLOCK_50_I(CLOCK_50_I),
			.resetn(resetn),
			.inc(letter_hit[i]),
			.count(counts[i])
		);
	end

	max_letter_select select_unit (
		.counts(counts),
		.any_pressed(any_pressed),
		.max_char(max_char),
		.max_count(max_count)
	);

	screen_overlay overlay_unit (
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.history(history),
		.any_pressed(any_pressed),
		.max_char(max_char),
		.max_count(max_count),
		.char_code(char_code),
		.border_on(border_on)
	);

endmodule

// ==== test/tb_key_stats_display.sv ====
// Directed tests of the keyboard statistics core; cell reads assume 8x8 cells and the fixed text layout
`include "key_display_settings.svh"

module tb_key_stats_display
	import key_display_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int NUM_EVENTS = 30; // Key events over all tests
	localparam int HOLD_EXTRA = 7; // Extra cycles of the held key
	localparam int NUM_READS = 348; // Cell and border reads, one cycle each
	localparam int NUM_RESETS = 2;
	localparam int WATCHDOG_TIME =
		(NUM_EVENTS * 6 + HOLD_EXTRA + NUM_READS + NUM_RESETS * 9) * CLK_PERIOD * 3 / 2;
	localparam int START_CELL = `MESSAGE_START_COL >> `CELL_SHIFT;
	localparam int CELL_SIZE = 1 << `CELL_SHIFT;
	localparam int COUNT_CELLS = 34; // A few cells past the longest message
	localparam int BORDER_R = `H_ACTIVE - `BORDER_OFFSET;
	localparam int BORDER_B = `V_ACTIVE - `BORDER_OFFSET;

	logic CLOCK_50_I;
	logic resetn;
	logic [7:0] scan_code;
	logic code_ready;
	logic make_code;
	pixel_coord_t pixel_x;
	pixel_coord_t pixel_y;
	char_code_t char_code;
	logic border_on;

	integer seed = 32'h9733_95d6;
	char_code_t hist_model[$]; // Newest first
	int count_model [`NUM_LETTERS];

	key_stats_display UUT (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.scan_code(scan_code),
		.code_ready(code_ready),
		.make_code(make_code),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.char_code(char_code),
		.border_on(border_on)
	);

	initial begin
		CLOCK_50_I = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50_I = ~CLOCK_50_I;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Simulation timed out after %0d time units", WATCHDOG_TIME);
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic int letter_index(input logic [7:0] code);
		int idx;
		case (code)
			`SCAN_A: idx = 0;
			`SCAN_B: idx = 1;
			`SCAN_C: idx = 2;
			`SCAN_D: idx = 3;
			`SCAN_E: idx = 4;
			`SCAN_F: idx = 5;
			default: idx = -1; // Not monitored
		endcase
		return idx;
	endfunction

	// Font ROM code of one character of a message, space past its end
	function automatic char_code_t text_code(input string text, input int k);
		char_code_t code;
		byte c;
		code = `CHAR_SPACE;
		if (k < text.len()) begin
			c = text[k];
			if (c >= "0" && c <= "9") begin
				code = `CHAR_DIGIT_BASE + char_code_t'(c - "0");
			end else if (c >= "A" && c <= "Z") begin
				code = `CHAR_LETTER_A + char_code_t'(c - "A");
			end
		end
		return code;
	endfunction

	// Expected count line from the model counts
	function automatic string count_text();
		int best;
		string text;
		best = -1;
		for (int i = 0; i < `NUM_LETTERS; i++) begin
			if (count_model[i] != 0 && (best < 0 || count_model[i] > count_model[best])) begin
				best = i; // Strictly greater, so ties keep the earlier letter
			end
		end
		if (best < 0) begin
			text = "NO MONITORED KEYS PRESSED";
		end else begin
			text = $sformatf("KEY %c PRESSED %0d TIMES", 8'("A" + best), count_model[best]);
		end
		return text;
	endfunction

	task automatic apply_reset();
		@(posedge CLOCK_50_I);
		#1;
		resetn = 1'b0;
		repeat (8) @(posedge CLOCK_50_I);
		#1;
		resetn = 1'b1;
		hist_model.delete();
		for (int i = 0; i < `NUM_LETTERS; i++) begin
			count_model[i] = 0;
		end
	endtask

	task automatic send_key(input logic [7:0] code, input logic make, input int hold);
		int idx;
		@(posedge CLOCK_50_I);
		#1;
		scan_code = code;
		make_code = make;
		code_ready = 1'b1;
		repeat (hold) @(posedge CLOCK_50_I);
		#1;
		code_ready = 1'b0;
		repeat (3) @(posedge CLOCK_50_I);
		if (make) begin
			idx = letter_index(code);
			if (idx < 0) begin
				hist_model.push_front(`CHAR_SPACE);
			end else begin
				hist_model.push_front(char_code_t'(`CHAR_LETTER_A + idx));
				count_model[idx] = (count_model[idx] + 1) % 100; // 99 wraps to 00
			end
			if (hist_model.size() > `HISTORY_LEN) begin
				void'(hist_model.pop_back());
			end
		end
	endtask

	task automatic press(input logic [7:0] code);
		send_key(code, 1'b1, 3);
	endtask

	task automatic read_cell(input int line, input int col, output char_code_t code);
		int dx;
		int dy;
		dx = $random(seed) & (CELL_SIZE - 1); // Any pixel inside the cell
		dy = $random(seed) & (CELL_SIZE - 1);
		@(posedge CLOCK_50_I);
		#1;
		pixel_x = pixel_coord_t'((START_CELL + col) * CELL_SIZE + dx);
		pixel_y = pixel_coord_t'(line + dy);
		#1;
		code = char_code;
	endtask

	task automatic check_history_row();
		char_code_t got;
		char_code_t expected;
		for (int k = 0; k <= `HISTORY_LEN; k++) begin
			read_cell(`HISTORY_LINE, k, got);
			expected = `CHAR_SPACE;
			if (k < `HISTORY_LEN && `HISTORY_LEN - 1 - k < hist_model.size()) begin
				expected = hist_model[`HISTORY_LEN - 1 - k]; // Newest at the right end
			end
			check($sformatf("char_code history cell %0d", k), 32'(got), 32'(expected));
		end
	endtask

	task automatic check_count_row();
		char_code_t got;
		string text;
		text = count_text();
		for (int k = 0; k < COUNT_CELLS; k++) begin
			read_cell(`COUNT_LINE, k, got);
			check($sformatf("char_code count cell %0d", k), 32'(got), 32'(text_code(text, k)));
		end
	endtask

	task automatic check_border(input int x, input int y, input logic expected);
		@(posedge CLOCK_50_I);
		#1;
		pixel_x = pixel_coord_t'(x);
		pixel_y = pixel_coord_t'(y);
		#1;
		check($sformatf("border_on at %0d,%0d", x, y), 32'(border_on), 32'(expected));
	endtask

	initial begin
		resetn = 1'b0;
		scan_code = '0;
		code_ready = 1'b0;
		make_code = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		apply_reset();

		// Blank history and the no keys message
		check_history_row();
		check_count_row();

		// Letters mixed with unmonitored keys
		press(`SCAN_A);
		press(8'h1B);
		press(`SCAN_B);
		press(`SCAN_C);
		press(8'h3A);
		press(`SCAN_D);
		press(`SCAN_E);
		press(`SCAN_F);
		check_history_row();
		check_count_row();

		// Break codes and a long ready level
		send_key(`SCAN_A, 1'b0, 3);
		send_key(8'h1B, 1'b0, 3);
		send_key(`SCAN_D, 1'b1, 3 + HOLD_EXTRA); // Counts once
		check_history_row();
		check_count_row();

		// Tie between B and A, then B ahead
		apply_reset();
		repeat (3) press(`SCAN_B);
		repeat (3) press(`SCAN_A);
		check_count_row();
		press(`SCAN_B);
		check_count_row();

		// Two digit count
		repeat (12) press(`SCAN_C);
		check_count_row();
		check_history_row();

		check_border(`BORDER_OFFSET, 100, 1'b1);
		check_border(`BORDER_OFFSET - 1, 100, 1'b0);
		check_border(`BORDER_OFFSET + 1, 100, 1'b0);
		check_border(BORDER_R, 300, 1'b1);
		check_border(BORDER_R - 1, 300, 1'b0);
		check_border(BORDER_R + 1, 300, 1'b0);
		check_border(400, `BORDER_OFFSET, 1'b1);
		check_border(400, `BORDER_OFFSET - 1, 1'b0);
		check_border(400, `BORDER_OFFSET + 1, 1'b0);
		check_border(400, BORDER_B, 1'b1);
		check_border(400, BORDER_B - 1, 1'b0);
		check_border(400, BORDER_B + 1, 1'b0);
		check_border(BORDER_R, BORDER_B - 1, 1'b1);
		check_border(BORDER_R, BORDER_B, 1'b0); // Half-open ranges miss this corner
		check_border(`BORDER_OFFSET, BORDER_B, 1'b1);
		check_border(`BORDER_OFFSET, `BORDER_OFFSET - 1, 1'b0);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/key_display_pkg.sv
verilog/key_event_decoder.sv
verilog/key_history.sv
verilog/bcd_letter_counter.sv
verilog/max_letter_select.sv
verilog/screen_overlay.sv
verilog/key_stats_display.sv
test/tb_key_stats_display.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_key_stats_display -f tb.f -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
echo "Simulation did not pass"
exit 1
